/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= qspi_dev_tb
DUT_TOP   ?= qspi_dev_top
FLIST     ?= qspi_dev_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* qspi_cmd_mem.sv */
`timescale 1ns/1ps

module qspi_cmd_mem import qspi_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,      // cs# fell, rewind the address
	input  qspi_insn_t insn,
	input  qspi_wr_t   wr,
	output logic       rd_mode,
	input  logic       rd_ready,
	output logic       rd_valid,
	output logic [7:0] rd_data
);

	logic [7:0]           mem [MEM_DEPTH];
	logic [MEM_AW-1:0]    addr;       // wraps at MEM_DEPTH
	logic [INSN_BITS-1:0] op_q;       // opcode of the current transaction
	logic [INSN_BITS-1:0] op_now;
	logic [7:0]           wr_count;   // whole bytes taken by the last write

	//////////////////////////////
	// decode

	// rd_ready comes with insn.valid, so the opcode is not latched yet there
	always_comb begin
		op_now  = insn.valid ? insn.data : op_q;
		rd_mode = (insn.data == OP_READ) || (insn.data == OP_STATUS);
	end

	//////////////////////////////
	// memory, address and count

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q     <= '0;
			addr     <= '0;
			wr_count <= '0;
			rd_valid <= 1'b0;
			rd_data  <= '0;
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;   // reads after reset give zeros
		end else begin
			rd_valid <= rd_ready;   // every request answered next clk

			if (insn.valid)
				op_q <= insn.data;
			if (insn.valid && (insn.data == OP_WRITE))
				wr_count <= '0;   // new write, count from zero

			// unknown opcodes also send bytes, they are dropped here
			if (wr.valid && (op_q == OP_WRITE)) begin
				mem[addr] <= wr.data;
				addr      <= addr + MEM_AW'(1);
				wr_count  <= wr_count + 8'd1;
			end

			if (rd_ready) begin
				case (op_now)
					OP_READ: begin
						rd_data <= mem[addr];
						addr    <= addr + MEM_AW'(1);
					end
					OP_STATUS: rd_data <= wr_count;   // same value every byte
					default:   rd_data <= 8'hFF;
				endcase
			end

			if (start)
				addr <= '0;
		end
	end

endmodule

/* qspi_dev_tb.sv */
`timescale 1ns/1ps

module qspi_dev_tb import qspi_pkg::*; ();

	//////////////////////////////
	// run constants and table

	localparam int SCK_HALF    = 8;     // clk per sck phase so the sck period is 16 clk
	localparam int MAX_BYTES   = 20;    // longest transfer in the table
	localparam int GAP_CLKS    = 16;    // idle between transactions
	localparam int NUM_TXN     = 14;
	localparam int CYC_PER_TXN = (4 + 2 * MAX_BYTES) * 2 * SCK_HALF + GAP_CLKS + 10;
	localparam int TIMEOUT_CYC = NUM_TXN * CYC_PER_TXN * 2;
	localparam logic [31:0] SEED = 32'd26826;

	// what the host expects back on dq_out
	localparam logic [1:0] SEL_NONE  = 2'd0;   // bus must stay released on writes
	localparam logic [1:0] SEL_MEM   = 2'd1;   // bytes of the memory model
	localparam logic [1:0] SEL_COUNT = 2'd2;   // write count on every byte

	typedef struct packed {
		logic [7:0] op;
		logic [7:0] nbytes;
		logic       early;   // stop one nibble into the next byte
		logic [1:0] sel;
	} txn_t;

	localparam txn_t TXN_TAB [NUM_TXN] = '{
		'{OP_STATUS, 8'd2,  1'b0, SEL_COUNT},   // count 0 out of reset
		'{OP_READ,   8'd4,  1'b0, SEL_MEM},     // memory all zeros
		'{OP_WRITE,  8'd5,  1'b0, SEL_NONE},
		'{OP_READ,   8'd5,  1'b0, SEL_MEM},
		'{OP_STATUS, 8'd3,  1'b0, SEL_COUNT},
		'{OP_WRITE,  8'd20, 1'b0, SEL_NONE},    // wraps past 16
		'{OP_READ,   8'd16, 1'b0, SEL_MEM},
		'{OP_STATUS, 8'd2,  1'b0, SEL_COUNT},
		'{OP_WRITE,  8'd3,  1'b1, SEL_NONE},    // half byte at the end is dropped
		'{OP_STATUS, 8'd2,  1'b0, SEL_COUNT},
		'{OP_READ,   8'd16, 1'b0, SEL_MEM},
		'{8'hA5,     8'd4,  1'b0, SEL_NONE},    // unknown opcode
		'{OP_READ,   8'd16, 1'b0, SEL_MEM},
		'{OP_STATUS, 8'd2,  1'b0, SEL_COUNT}
	};

	logic       clk;
	logic       rst_n;
	logic       sck;
	logic       cs_n;
	logic [3:0] dq_in;
	logic [3:0] dq_out;
	logic       dq_oe;

	int          errors;
	int          checks;
	int          cycle_count = 0;
	logic [31:0] seed;
	logic [7:0]  mem_model [MEM_DEPTH];
	logic [7:0]  count_model;   // whole bytes of the last write

	qspi_dev_top i_qspi_dev_top (
		.clk    (clk),
		.rst_n  (rst_n),
		.sck    (sck),
		.cs_n   (cs_n),
		.dq_in  (dq_in),
		.dq_out (dq_out),
		.dq_oe  (dq_oe)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// all drives land 1 ns after a rising clk
	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_byte(input int idx, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0d ns: dq_out byte %0d expected %02h got %02h",
				$time, idx, exp, got);
		end
	endtask

	// one host transaction bit-banged on sck falling edges
	task automatic run_txn(input txn_t t);
		logic [7:0] wbytes [$];
		logic [7:0] got;
		logic [7:0] exp;
		logic [3:0] nib;
		bit         is_rd;
		int         n_edges;
		int         k;
		int         lat;
		is_rd = (t.sel != SEL_NONE);
		got   = '0;
		for (int i = 0; i < int'(t.nbytes); i++) begin
			seed = lcg_next(seed);
			wbytes.push_back(seed[23:16]);
		end
		// 2 insn edges, turnaround, then 2 edges per byte
		if (is_rd)
			n_edges = 2 + 2 * int'(t.nbytes);
		else
			n_edges = 3 + 2 * int'(t.nbytes) + int'(t.early);

		cs_n = 1'b0;
		for (int e = 1; e <= n_edges; e++) begin
			if (e == 1)
				nib = t.op[7:4];   // opcode msb nibble first
			else if (e == 2)
				nib = t.op[3:0];
			else if (is_rd || e == 3)
				nib = 4'h0;        // value unused on the turnaround and on reads
			else begin
				k = (e - 4) / 2;
				if (k >= int'(t.nbytes))
					nib = 4'hC;    // trailing half byte
				else if (((e - 4) % 2) == 0)
					nib = wbytes[k][7:4];
				else
					nib = wbytes[k][3:0];
			end
			dq_in = nib;
			wait_clks(SCK_HALF);
			sck = 1'b1;
			wait_clks(SCK_HALF);
			sck = 1'b0;

			// sample what the device drove on edge e
			if (is_rd && e >= 3) begin
				checks++;
				if (dq_oe !== 1'b1) begin
					errors++;
					$display("Fail %0d ns: dq_oe expected 1 got %b", $time, dq_oe);
				end
				k = (e - 3) / 2;
				if (((e - 3) % 2) == 0) begin
					got[7:4] = dq_out;
				end else begin
					got[3:0] = dq_out;
					if (t.sel == SEL_MEM)
						exp = mem_model[MEM_AW'(k)];
					else
						exp = count_model;
					check_byte(k, exp, got);
				end
			end
			if (!is_rd && dq_oe !== 1'b0) begin
				errors++;
				$display("Fail %0d ns: dq_oe expected 0 got %b", $time, dq_oe);
			end
		end

		// release and time the bus turn-off
		cs_n  = 1'b1;
		dq_in = 4'h0;
		lat   = 0;
		while (dq_oe !== 1'b0 && lat < 10) begin
			wait_clks(1);
			lat++;
		end
		checks++;
		if (dq_oe !== 1'b0 || lat > 6) begin
			errors++;
			$display("dq_oe did not fall within 6 clk of cs_n rising (%0d clk)", lat);
		end
		wait_clks(GAP_CLKS);

		// only a real write touches the memory and count models
		if (t.op == OP_WRITE) begin
			for (int i = 0; i < int'(t.nbytes); i++)
				mem_model[MEM_AW'(i)] = wbytes[i];
			count_model = t.nbytes;
		end
	endtask

	//////////////////////////////
	// main sequence

	initial begin
		rst_n       = 1'b0;
		sck         = 1'b0;
		cs_n        = 1'b1;
		dq_in       = 4'h0;
		errors      = 0;
		checks      = 0;
		seed        = SEED;
		count_model = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			mem_model[i] = '0;

		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		wait_clks(4);
		checks++;
		if (dq_oe !== 1'b0) begin
			errors++;
			$display("Fail %0d ns: dq_oe expected 0 got %b", $time, dq_oe);
		end

		for (int i = 0; i < NUM_TXN; i++)
			run_txn(TXN_TAB[i]);

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// guard against a stuck host loop
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYC) begin
			$display("timeout, run did not finish in %0d clk cycles", TIMEOUT_CYC);
			$display("checks: %0d  errors: %0d", checks, errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

/* qspi_dev_top.f */
qspi_pkg.sv
qspi_sync.sv
qspi_xcvr.sv
qspi_cmd_mem.sv
qspi_dev_top.sv
qspi_dev_tb.sv

/* qspi_dev_top.sv */
`timescale 1ns/1ps

module qspi_dev_top import qspi_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sck,
	input  logic       cs_n,
	input  logic [3:0] dq_in,
	output logic [3:0] dq_out,
	output logic       dq_oe      // pad buffer lives outside
);

	qspi_sample_t smp;
	qspi_insn_t   insn;
	qspi_wr_t     wr;

	// read handshake between transceiver and memory
	logic       rd_mode;
	logic       rd_ready;
	logic       rd_valid;
	logic [7:0] rd_data;

	//////////////////////////////
	// stage 1, sync and edges

	qspi_sync i_qspi_sync (
		.clk   (clk),
		.rst_n (rst_n),
		.sck   (sck),
		.cs_n  (cs_n),
		.dq_in (dq_in),
		.smp   (smp)
	);

	//////////////////////////////
	// stage 2, transceiver

	qspi_xcvr i_qspi_xcvr (
		.clk      (clk),
		.rst_n    (rst_n),
		.smp      (smp),
		.insn     (insn),
		.wr       (wr),
		.rd_mode  (rd_mode),
		.rd_ready (rd_ready),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.dq_out   (dq_out),
		.dq_oe    (dq_oe)
	);

	//////////////////////////////
	// stage 3, commands and scratch memory

	qspi_cmd_mem i_qspi_cmd_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (smp.start),
		.insn     (insn),
		.wr       (wr),
		.rd_mode  (rd_mode),
		.rd_ready (rd_ready),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

endmodule

/* qspi_pkg.sv */
package qspi_pkg;

	//////////////////////////////
	// link and memory geometry

	localparam int INSN_BITS   = 8;    // single instruction byte, sent as two nibbles
	localparam int MEM_DEPTH   = 16;   // scratch bytes
	localparam int MEM_AW      = 4;    // log2 of MEM_DEPTH
	localparam int SYNC_STAGES = 3;    // flops per synchronized line

	// instruction set served by the command stage
	localparam logic [INSN_BITS-1:0] OP_WRITE  = 8'h32;
	localparam logic [INSN_BITS-1:0] OP_READ   = 8'h6B;
	localparam logic [INSN_BITS-1:0] OP_STATUS = 8'h05;

	//////////////////////////////
	// stage payloads

	// sync stage -> transceiver, one per clk
	typedef struct packed {
		logic       start;      // cs# fell
		logic       stop;       // cs# rose
		logic       sck_rise;   // synchronized sck rising edge
		logic       cs_active;  // synchronized cs#, inverted
		logic [3:0] dq;         // synchronized dq lines
	} qspi_sample_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} qspi_wr_t;

	typedef struct packed {
		logic                 valid;
		logic [INSN_BITS-1:0] data;
	} qspi_insn_t;

endpackage

/* qspi_sync.sv */
`timescale 1ns/1ps

module qspi_sync import qspi_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         sck,
	input  logic         cs_n,
	input  logic [3:0]   dq_in,
	output qspi_sample_t smp
);

	//////////////////////////////
	// synchronizer chains

	// bit 0 is the first flop, top bit is the synchronized value
	logic [SYNC_STAGES-1:0]      sck_sr;
	logic [SYNC_STAGES-1:0]      cs_n_sr;
	logic [SYNC_STAGES-1:0][3:0] dq_sr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_sr  <= '0;
			cs_n_sr <= '1;   // deselected level, no false start out of reset
			dq_sr   <= '0;
		end else begin
			sck_sr  <= {sck_sr[SYNC_STAGES-2:0], sck};
			cs_n_sr <= {cs_n_sr[SYNC_STAGES-2:0], cs_n};
			dq_sr   <= {dq_sr[SYNC_STAGES-2:0], dq_in};
		end
	end

	logic       sck_sync;
	logic       cs_n_sync;
	logic [3:0] dq_sync;

	assign sck_sync  = sck_sr[SYNC_STAGES-1];
	assign cs_n_sync = cs_n_sr[SYNC_STAGES-1];
	assign dq_sync   = dq_sr[SYNC_STAGES-1];

	//////////////////////////////
	// edge detection

	logic sck_ff;    // one clk behind sck_sync
	logic cs_n_ff;
	logic start_q;   // registered cs# edges
	logic stop_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_ff  <= 1'b0;
			cs_n_ff <= 1'b1;
			start_q <= 1'b0;
			stop_q  <= 1'b0;
		end else begin
			sck_ff  <= sck_sync;
			cs_n_ff <= cs_n_sync;
			start_q <= !cs_n_sync && cs_n_ff;   // falling cs#
			stop_q  <= cs_n_sync && !cs_n_ff;   // rising cs#
		end
	end

	// sck edge is combinational so the transceiver sees it with the data it goes with
	always_comb begin
		smp.start     = start_q;
		smp.stop      = stop_q;
		smp.sck_rise  = sck_sync && !sck_ff;
		smp.cs_active = !cs_n_sync;
		smp.dq        = dq_sync;
	end

endmodule

/* qspi_xcvr.sv */
`timescale 1ns/1ps

module qspi_xcvr import qspi_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  qspi_sample_t smp,
	output qspi_insn_t   insn,
	output qspi_wr_t     wr,
	input  logic         rd_mode,    // from cmd stage, valid alongside insn.valid
	output logic         rd_ready,   // request next read byte
	input  logic         rd_valid,
	input  logic [7:0]   rd_data,
	output logic [3:0]   dq_out,
	output logic         dq_oe
);

	//////////////////////////////
	// state encoding

	typedef enum logic [2:0] {
		ST_DESEL = 3'd0,
		ST_INSN  = 3'd1,
		ST_TURN  = 3'd2,
		ST_WR_HI = 3'd3,
		ST_WR_LO = 3'd4,
		ST_RD_HI = 3'd5,
		ST_RD_LO = 3'd6
	} state_t;

	state_t     state;
	logic [3:0] insn_count;     // instruction nibbles taken so far
	logic [3:0] dq_in_ff;       // last sampled nibble, high half of a write byte
	logic [7:0] rd_data_next;   // held copy of the last read byte
	logic [7:0] rd_data_fwd;

	//////////////////////////////
	// read data forwarding

	// answer lands one clk after rd_ready, use it straight away if it is there
	always_comb begin
		rd_data_fwd = rd_data_next;
		if (rd_valid)
			rd_data_fwd = rd_data;
	end

	// first byte asked for with the instruction, the rest as each low nibble leaves
	always_comb begin
		rd_ready = 1'b0;
		if (insn.valid)
			rd_ready = 1'b1;
		if ((state == ST_RD_LO) && smp.sck_rise)
			rd_ready = 1'b1;
	end

	//////////////////////////////
	// main fsm

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ST_DESEL;
			insn_count   <= '0;
			insn         <= '0;
			wr           <= '0;
			dq_in_ff     <= '0;
			rd_data_next <= '0;
			dq_out       <= '0;
			dq_oe        <= 1'b0;
		end else begin
			insn.valid   <= 1'b0;   // strobes, one cycle only
			wr.valid     <= 1'b0;
			rd_data_next <= rd_data_fwd;

			// everything moves on the synchronized sck rising edge
			if (smp.sck_rise) begin
				dq_in_ff <= smp.dq;

				case (state)
					ST_DESEL: begin
						// idle until cs# falls
					end

					// instruction, msb nibble first
					ST_INSN: begin
						insn.data  <= {insn.data[INSN_BITS-5:0], smp.dq};
						insn_count <= insn_count + 4'd1;
						if ((insn_count + 4'd1) == 4'(INSN_BITS / 4)) begin
							insn.valid <= 1'b1;
							state      <= ST_TURN;
						end
					end

					// one dummy edge; a read starts driving here
					ST_TURN: begin
						if (rd_mode) begin
							dq_oe  <= 1'b1;
							dq_out <= rd_data_fwd[7:4];   // high nibble on the turnaround
							state  <= ST_RD_LO;
						end else begin
							state <= ST_WR_HI;
						end
					end

					ST_WR_HI: begin
						state <= ST_WR_LO;   // high nibble parked in dq_in_ff
					end

					ST_WR_LO: begin
						wr.valid <= 1'b1;
						wr.data  <= {dq_in_ff, smp.dq};
						state    <= ST_WR_HI;
					end

					ST_RD_HI: begin
						dq_out <= rd_data_fwd[7:4];
						state  <= ST_RD_LO;
					end

					// low nibble out, next byte requested on this same edge
					ST_RD_LO: begin
						dq_out <= rd_data_fwd[3:0];
						state  <= ST_RD_HI;
					end

					default: begin
						state <= ST_DESEL;
					end
				endcase
			end

			if (smp.stop)
				dq_out <= 4'h0;   // park the bus value between transfers

			// deselect wins over anything above, release the bus at once
			if (!smp.cs_active) begin
				state <= ST_DESEL;
				dq_oe <= 1'b0;
			end

			if (smp.start) begin
				state      <= ST_INSN;
				insn_count <= '0;
				insn.data  <= '0;
			end
		end
	end

endmodule
